// File: Bender.yml
package:
  name: pipeCtrl

export_include_dirs:
  - hw

sources:
  - hw/pipeCtrlPkg.sv
  - hw/hazardDetect.sv
  - hw/mulDivSequencer.sv
  - hw/pipeControl.sv
  - hw/pipeCtrlTop.sv
  - target: simulation
    files:
      - sim/pipeCtrl_properties.sv
      - sim/pipeCtrlTb.sv

// File: hw/hazardDetect.sv
// Load-use hazard detection
module hazardDetect (
    input  pipeCtrlPkg::regAddrT idRs,
    input  pipeCtrlPkg::regAddrT idRt,
    input  logic                 idUsesRs,
    input  logic                 idUsesRt,
    input  pipeCtrlPkg::regAddrT exeWrReg,
    input  logic                 exeIsLoad,
    input  pipeCtrlPkg::regAddrT memWrReg,
    input  logic                 memIsLoad,
    input  pipeCtrlPkg::regAddrT mem2WrReg,
    input  logic                 mem2IsLoad,
    output logic                 exDhStall,
    output logic                 memDhStall,
    output logic                 mem2DhStall
);
    import pipeCtrlPkg::*;

    // one load stage against both id operands
    function automatic logic loadUse(
        input regAddrT dstReg,
        input logic    isLoad,
        input regAddrT rs,
        input logic    usesRs,
        input regAddrT rt,
        input logic    usesRt
    );
        logic rsHit;
        logic rtHit;
        rsHit = usesRs && (rs == dstReg);
        rtHit = usesRt && (rt == dstReg);
        // $zero is never a real destination
        return isLoad && (dstReg != regAddrT'(0)) && (rsHit || rtHit);
    endfunction

    // stages are checked independently, priority lives in pipeControl
    always_comb begin
        exDhStall   = loadUse(exeWrReg, exeIsLoad, idRs, idUsesRs, idRt, idUsesRt);
        memDhStall  = loadUse(memWrReg, memIsLoad, idRs, idUsesRs, idRt, idUsesRt);
        mem2DhStall = loadUse(mem2WrReg, mem2IsLoad, idRs, idUsesRs, idRt, idUsesRt);
    end

endmodule

// File: hw/mulDivSequencer.sv
// Multiply/divide busy sequencer
`include "pipeCtrl_defs.svh"

module mulDivSequencer (
    input  logic clk,
    input  logic arstN,
    input  logic exeMulDivStart,
    input  logic exeWr,
    output logic mulDivBusy
);
    import pipeCtrlPkg::*;

    mulDivStateT state;
    mulDivStateT stateNext;
    mulDivCntT   cnt;
    mulDivCntT   cntNext;

    always_comb begin
        stateNext = state;
        cntNext   = cnt;
        case (state)
            mdIdle: begin
                if (exeMulDivStart) begin
                    stateNext = mdBusy;
                    // counts down to zero, one busy cycle per value
                    cntNext   = mulDivCntT'(`MULDIV_CYCLES - 1);
                end
            end
            mdBusy: begin
                if (cnt == mulDivCntT'(0)) begin
                    stateNext = mdDone;
                end else begin
                    cntNext = cnt - mulDivCntT'(1);
                end
            end
            mdDone: begin
                // the finished op leaves exe once exeWr is seen
                if (exeWr) begin
                    stateNext = mdIdle;
                end
            end
            default: begin
                stateNext = mdIdle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= mdIdle;
            cnt   <= '0;
        end else begin
            state <= stateNext;
            cnt   <= cntNext;
        end
    end

    assign mulDivBusy = (state == mdBusy);

endmodule

// File: hw/pipeControl.sv
// Pipeline stall and flush priority decoder
`include "pipeCtrl_defs.svh"

module pipeControl (
    input  logic flushException,
    input  logic iTlbStall,
    input  logic dTlbStall,
    input  logic iCacheBusy,
    input  logic dCacheBusy,
    input  logic exDhStall,
    input  logic memDhStall,
    input  logic mem2DhStall,
    input  logic exePredictFailed,
    input  logic exePfFlushAll,
    input  logic exeIsBranchLikely,
    input  logic exeIsTaken,
    input  logic mulDivBusy,
    output logic preIfWr,
    output logic ifWr,
    output logic idWr,
    output logic exeWr,
    output logic memWr,
    output logic mem2Wr,
    output logic wbWr,
    output logic ifFlush,
    output logic idFlush,
    output logic exeFlush,
    output logic memFlush,
    output logic mem2Flush,
    output logic wbFlush,
    output logic idDisWr,
    output logic exeDisWr,
    output logic memDisWr,
    output logic wbDisWr,
    output logic iReqValid,
    output logic dReqValid,
    output logic iCacheStall,
    output logic dCacheStall
);
    logic excFlush;
    logic likelyFlush;
    logic holdAll;

    assign excFlush    = (flushException == `FLUSH_ENABLE);
    // taken branch-likely kills its delay slot in exe
    assign likelyFlush = exeIsBranchLikely && exeIsTaken;
    // d side ranks over i side over mul/div, all freeze the same way
    assign holdAll     = dTlbStall || dCacheBusy || iTlbStall || iCacheBusy || mulDivBusy;

    always_comb begin
        {preIfWr, ifWr, idWr, exeWr, memWr, mem2Wr, wbWr} = '0;
        {ifFlush, idFlush, exeFlush, memFlush, mem2Flush, wbFlush} = '0;
        {idDisWr, memDisWr, wbDisWr} = '0;
        {iCacheStall, dCacheStall} = '0;
        if (holdAll) begin
            memDisWr    = 1'b1;
            wbDisWr     = 1'b1;
            iCacheStall = 1'b1;
            dCacheStall = 1'b1;
        end else if (excFlush) begin
            // let mem2 and wb retire, restart fetch at the handler
            {preIfWr, mem2Wr, wbWr} = '1;
            {ifFlush, idFlush, exeFlush, memFlush} = '1;
            memDisWr = 1'b1;
        end else if (exePfFlushAll) begin
            {preIfWr, exeWr, memWr, mem2Wr, wbWr} = '1;
            {ifFlush, idFlush, exeFlush} = '1;
        end else if (mem2DhStall) begin
            {mem2Wr, wbWr} = '1;
            mem2Flush   = 1'b1;
            memDisWr    = 1'b1;
            iCacheStall = 1'b1;
        end else if (memDhStall) begin
            {memWr, mem2Wr, wbWr} = '1;
            memFlush    = 1'b1;
            iCacheStall = 1'b1;
        end else if (exDhStall) begin
            {exeWr, memWr, mem2Wr, wbWr} = '1;
            exeFlush    = 1'b1;
            idDisWr     = 1'b1;
            iCacheStall = 1'b1;
        end else if (exePredictFailed) begin
            {preIfWr, exeWr, memWr, mem2Wr, wbWr} = '1;
            {ifFlush, idFlush} = '1;
            exeFlush = likelyFlush;
        end else begin
            {preIfWr, ifWr, idWr, exeWr, memWr, mem2Wr, wbWr} = '1;
            exeFlush = likelyFlush;
        end
    end

    // blocks hi/lo writes from the instruction in exe
    always_comb begin
        if (excFlush) begin
            exeDisWr = 1'b1;
        end else if (exePfFlushAll) begin
            exeDisWr = 1'b0;
        end else begin
            exeDisWr = memDhStall || mulDivBusy;
        end
    end

    // no new fetch while fetch is about to be redirected or held
    assign iReqValid = !(excFlush || mem2DhStall || memDhStall || exDhStall ||
                         exePredictFailed || exePfFlushAll);
    assign dReqValid = !excFlush;

endmodule

// File: hw/pipeCtrlPkg.sv
// Pipeline control types
`include "pipeCtrl_defs.svh"

package pipeCtrlPkg;

    // architectural register number
    typedef logic [`REG_ADDR_W-1:0] regAddrT;

    // multiply/divide busy counter
    typedef logic [`MULDIV_CNT_W-1:0] mulDivCntT;

    // multiply/divide sequencer states
    typedef enum logic [1:0] {
        mdIdle,
        mdBusy,
        // result ready, waiting for exe to advance
        mdDone
    } mulDivStateT;

endpackage

// File: hw/pipeCtrlTop.sv
// Pipeline hazard and flush control
module pipeCtrlTop (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 flushException,
    input  logic                 iTlbStall,
    input  logic                 dTlbStall,
    input  logic                 iCacheBusy,
    input  logic                 dCacheBusy,
    input  pipeCtrlPkg::regAddrT idRs,
    input  pipeCtrlPkg::regAddrT idRt,
    input  logic                 idUsesRs,
    input  logic                 idUsesRt,
    input  pipeCtrlPkg::regAddrT exeWrReg,
    input  logic                 exeIsLoad,
    input  pipeCtrlPkg::regAddrT memWrReg,
    input  logic                 memIsLoad,
    input  pipeCtrlPkg::regAddrT mem2WrReg,
    input  logic                 mem2IsLoad,
    input  logic                 exePredictFailed,
    input  logic                 exePfFlushAll,
    input  logic                 exeIsBranchLikely,
    input  logic                 exeIsTaken,
    input  logic                 exeMulDivStart,
    output logic                 preIfWr,
    output logic                 ifWr,
    output logic                 idWr,
    output logic                 exeWr,
    output logic                 memWr,
    output logic                 mem2Wr,
    output logic                 wbWr,
    output logic                 ifFlush,
    output logic                 idFlush,
    output logic                 exeFlush,
    output logic                 memFlush,
    output logic                 mem2Flush,
    output logic                 wbFlush,
    output logic                 idDisWr,
    output logic                 exeDisWr,
    output logic                 memDisWr,
    output logic                 wbDisWr,
    output logic                 iReqValid,
    output logic                 dReqValid,
    output logic                 iCacheStall,
    output logic                 dCacheStall
);
    logic exDhStall;
    logic memDhStall;
    logic mem2DhStall;
    logic mulDivBusy;

    hazardDetect u_hazardDetect (.*);

    // exeWr closes the loop, busy is registered so no comb path
    mulDivSequencer u_mulDivSequencer (
        .clk            (clk),
        .arstN          (arstN),
        .exeMulDivStart (exeMulDivStart),
        .exeWr          (exeWr),
        .mulDivBusy     (mulDivBusy)
    );

    pipeControl u_pipeControl (.*);

endmodule

// File: hw/pipeCtrl_defs.svh
// Pipeline control constants
`ifndef PIPECTRL_DEFS_SVH
`define PIPECTRL_DEFS_SVH

// register number width, 32 architectural registers
`define REG_ADDR_W 5

// busy cycles of one multiply or divide
`define MULDIV_CYCLES 4

// wide enough to hold MULDIV_CYCLES - 1
`define MULDIV_CNT_W 3

// active level of the exception flush
`define FLUSH_ENABLE 1'b1

`endif

// File: pipeCtrl.f
+incdir+hw
hw/pipeCtrlPkg.sv
hw/hazardDetect.sv
hw/mulDivSequencer.sv
hw/pipeControl.sv
hw/pipeCtrlTop.sv
sim/pipeCtrl_properties.sv
sim/pipeCtrlTb.sv

// File: sim/pipeCtrlTb.sv
// Pipeline control testbench
`include "pipeCtrl_defs.svh"

module pipeCtrlTb;
    timeunit 1ns;
    timeprecision 1ps;
    import pipeCtrlPkg::*;

    logic    clk;
    logic    arstN;
    logic    flushException, iTlbStall, dTlbStall, iCacheBusy, dCacheBusy;
    regAddrT idRs, idRt, exeWrReg, memWrReg, mem2WrReg;
    logic    idUsesRs, idUsesRt, exeIsLoad, memIsLoad, mem2IsLoad;
    logic    exePredictFailed, exePfFlushAll, exeIsBranchLikely, exeIsTaken;
    logic    exeMulDivStart;
    logic    preIfWr, ifWr, idWr, exeWr, memWr, mem2Wr, wbWr;
    logic    ifFlush, idFlush, exeFlush, memFlush, mem2Flush, wbFlush;
    logic    idDisWr, exeDisWr, memDisWr, wbDisWr;
    logic    iReqValid, dReqValid, iCacheStall, dCacheStall;

    // sequencer mirror: 0 idle, 1 busy, 2 done
    int      mdState;
    int      mdCnt;
    logic    expExeWr;
    integer  seed;
    int      holdCycles;

    pipeCtrlTop u_pipeCtrlTop (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            failRun($sformatf("MISMATCH %s expected %0h actual %0h", name, expected, actual));
        end
    endtask

    task automatic driveQuiet;
        {flushException, iTlbStall, dTlbStall, iCacheBusy, dCacheBusy} = '0;
        {idRs, idRt, exeWrReg, memWrReg, mem2WrReg} = '0;
        {idUsesRs, idUsesRt, exeIsLoad, memIsLoad, mem2IsLoad} = '0;
        {exePredictFailed, exePfFlushAll, exeIsBranchLikely, exeIsTaken} = '0;
        exeMulDivStart = 1'b0;
    endtask

    // roughly one in eight
    function automatic logic rare;
        return ($random(seed) & 7) == 0;
    endfunction

    task automatic driveRandom;
        {flushException, iTlbStall, dTlbStall} = {rare(), rare(), rare()};
        {iCacheBusy, dCacheBusy, exeMulDivStart} = {rare(), rare(), rare()};
        {exePredictFailed, exePfFlushAll} = {rare(), rare()};
        {exeIsBranchLikely, exeIsTaken} = 2'($random(seed));
        {idUsesRs, idUsesRt} = 2'($random(seed));
        {exeIsLoad, memIsLoad, mem2IsLoad} = 3'($random(seed));
        // small register range so matches are common
        idRs      = regAddrT'($random(seed) & 3);
        idRt      = regAddrT'($random(seed) & 3);
        exeWrReg  = regAddrT'($random(seed) & 3);
        memWrReg  = regAddrT'($random(seed) & 3);
        mem2WrReg = regAddrT'($random(seed) & 3);
    endtask

    function automatic logic loadHit(input regAddrT dst, input logic isLoad);
        return isLoad && (dst != '0) &&
               ((idUsesRs && idRs == dst) || (idUsesRt && idRt == dst));
    endfunction

    task automatic checkOutputs(input string name);
        logic       exH, memH, mem2H, busy, likely;
        logic [6:0] wr;   // preIf if id exe mem mem2 wb
        logic [5:0] fl;   // if id exe mem mem2 wb
        logic [3:0] dis;  // id exe mem wb
        logic [1:0] cst;  // iCacheStall dCacheStall
        logic [1:0] req;  // iReqValid dReqValid
        exH    = loadHit(exeWrReg, exeIsLoad);
        memH   = loadHit(memWrReg, memIsLoad);
        mem2H  = loadHit(mem2WrReg, mem2IsLoad);
        busy   = (mdState == 1);
        likely = exeIsBranchLikely && exeIsTaken;
        {wr, fl, dis, cst} = '0;
        if (dTlbStall || dCacheBusy || iTlbStall || iCacheBusy || busy) begin
            dis = 4'b0011;
            cst = 2'b11;
        end else if (flushException) begin
            {wr, fl, dis} = {7'b1000011, 6'b111100, 4'b0010};
        end else if (exePfFlushAll) begin
            {wr, fl} = {7'b1001111, 6'b111000};
        end else if (mem2H) begin
            {wr, fl, dis, cst} = {7'b0000011, 6'b000010, 4'b0010, 2'b10};
        end else if (memH) begin
            {wr, fl, cst} = {7'b0000111, 6'b000100, 2'b10};
        end else if (exH) begin
            {wr, fl, dis, cst} = {7'b0001111, 6'b001000, 4'b1000, 2'b10};
        end else if (exePredictFailed) begin
            {wr, fl} = {7'b1001111, 2'b11, likely, 3'b000};
        end else begin
            {wr, fl} = {7'b1111111, 2'b00, likely, 3'b000};
        end
        // exeDisWr has its own chain
        if (flushException) begin
            dis[2] = 1'b1;
        end else if (!exePfFlushAll) begin
            dis[2] = memH || busy;
        end
        req[1] = !(flushException || exH || memH || mem2H || exePredictFailed || exePfFlushAll);
        req[0] = !flushException;
        expExeWr = wr[3];
        checkValue({name, " wr"}, wr, {preIfWr, ifWr, idWr, exeWr, memWr, mem2Wr, wbWr});
        checkValue({name, " flush"}, fl, {ifFlush, idFlush, exeFlush, memFlush, mem2Flush, wbFlush});
        checkValue({name, " disWr"}, dis, {idDisWr, exeDisWr, memDisWr, wbDisWr});
        checkValue({name, " cache"}, {req, cst}, {iReqValid, dReqValid, iCacheStall, dCacheStall});
    endtask

    task automatic advanceModel;
        if (mdState == 0 && exeMulDivStart) begin
            mdState = 1;
            mdCnt   = `MULDIV_CYCLES - 1;
        end else if (mdState == 1) begin
            mdState = (mdCnt == 0) ? 2 : 1;
            mdCnt   = (mdCnt == 0) ? 0 : mdCnt - 1;
        end else if (mdState == 2 && expExeWr) begin
            mdState = 0;
        end
    endtask

    // inputs were driven at the falling edge just before
    task automatic stepCycle(input string name);
        #2;
        checkOutputs(name);
        @(posedge clk);
        advanceModel();
        @(negedge clk);
    endtask

    // inputs held, so preIfWr at the falling edge shows the new state
    task automatic countHold(input string name, output int cycles);
        cycles = 0;
        while (!preIfWr) begin
            cycles++;
            if (cycles > `MULDIV_CYCLES + 8) begin
                failRun({name, ": multiply/divide hold did not clear before the timeout"});
            end
            stepCycle(name);
        end
    endtask

    initial begin
        seed     = 15087;
        mdState  = 0;
        mdCnt    = 0;
        expExeWr = 1'b0;
        arstN    = 1'b0;
        driveQuiet();
        repeat (10) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        stepCycle("reset values");
        stepCycle("reset values");

        idRs     = regAddrT'(2);
        idUsesRs = 1'b1;
        {exeWrReg, exeIsLoad} = {regAddrT'(2), 1'b1};
        stepCycle("hazard exe");
        {memWrReg, memIsLoad} = {regAddrT'(2), 1'b1};
        stepCycle("hazard mem over exe");
        {mem2WrReg, mem2IsLoad} = {regAddrT'(2), 1'b1};
        stepCycle("hazard mem2 over mem");
        idUsesRs = 1'b0;
        stepCycle("hazard unused source");
        driveQuiet();
        {idUsesRs, idUsesRt, exeIsLoad, memIsLoad, mem2IsLoad} = '1;
        stepCycle("hazard register zero");

        driveQuiet();
        exeMulDivStart = 1'b1;
        stepCycle("muldiv start");
        countHold("muldiv first burst", holdCycles);
        checkValue("muldiv first length", `MULDIV_CYCLES, holdCycles);
        // frozen in done, start still high must not restart
        dCacheBusy = 1'b1;
        repeat (3) stepCycle("muldiv done frozen");
        dCacheBusy = 1'b0;
        stepCycle("muldiv release");
        stepCycle("muldiv restart");
        countHold("muldiv second burst", holdCycles);
        checkValue("muldiv second length", `MULDIV_CYCLES, holdCycles);

        driveQuiet();
        {exePredictFailed, exeIsBranchLikely, exeIsTaken} = 3'b111;
        stepCycle("mispredict likely taken");
        exeIsTaken = 1'b0;
        stepCycle("mispredict likely not taken");
        {exePredictFailed, exeIsTaken} = 2'b01;
        stepCycle("likely taken");
        {flushException, exePfFlushAll, dCacheBusy} = 3'b110;
        stepCycle("exception over flush all");

        repeat (3000) begin
            driveRandom();
            stepCycle("random");
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: sim/pipeCtrl_properties.sv
// Pipeline control assertions
module pipeCtrlProperties (
    input logic clk,
    input logic arstN,
    input logic flushException, exePfFlushAll, exePredictFailed,
    input logic dTlbStall, dCacheBusy, iTlbStall, iCacheBusy, mulDivBusy,
    input logic preIfWr, ifWr, idWr, exeWr, memWr, mem2Wr, wbWr,
    input logic ifFlush, idFlush, wbFlush,
    input logic dReqValid
);
    timeunit 1ns;
    timeprecision 1ps;

    logic holdCause;
    logic anyWr;

    assign holdCause = dTlbStall || dCacheBusy || iTlbStall || iCacheBusy || mulDivBusy;
    assign anyWr     = preIfWr || ifWr || idWr || exeWr || memWr || mem2Wr || wbWr;

    // a freeze cause stops every stage
    holdStopsAll: assert property (@(posedge clk) disable iff (!arstN) holdCause |-> !anyWr)
        else $error("write enable high during a hold");

    dReqFollowsFlush: assert property (@(posedge clk) disable iff (!arstN)
        dReqValid == !flushException) else $error("dReqValid not inverse of exception flush");

    wbNeverFlushed: assert property (@(posedge clk) disable iff (!arstN) !wbFlush)
        else $error("wbFlush asserted");

    // front stages are only killed without a write on a fetch redirect
    frontFlushOnRedirect: assert property (@(posedge clk) disable iff (!arstN)
        ((ifFlush && !ifWr) || (idFlush && !idWr)) |->
        (flushException || exePfFlushAll || exePredictFailed))
        else $error("front stage flushed without a redirect");

endmodule

// pipeControl has no clock, so attach where clk and the internal busy are visible
bind pipeCtrlTop pipeCtrlProperties u_pipeCtrlProperties (.*);
